/* sim.f */
hdl/wbuf_pkg.sv
hdl/wbuf_dir.sv
hdl/wbuf_data_store.sv
hdl/wbuf_send_queue.sv
hdl/wbuf_top.sv
verification/wbuf_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
{ verilator --binary --timing -Wno-fatal --top-module wbuf_tb -f sim.f -o wbuf_sim \
    && ./obj_dir/wbuf_sim; } > sim.log 2>&1 || echo "Test failures found" >> sim.log
cat sim.log
grep -q "Test failures found" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

/* verification/wbuf_tb.sv */
// Expects sends in write order; acks return in send order, three cycles after each send
`timescale 1ns/100ps
module wbuf_tb;

    logic clk_i = 1'b0;
    logic rst_ni;
    logic [wbuf_pkg::WBUF_TIMECNT_WIDTH-1:0] cfg_threshold_i;
    logic cfg_reset_timecnt_on_write_i;
    logic cfg_sequential_waw_i;
    logic close_all_i;
    logic write_i;
    logic write_ready_o;
    logic [wbuf_pkg::WBUF_PA_WIDTH-1:0] write_addr_i;
    logic [wbuf_pkg::WBUF_WORD_WIDTH-1:0] write_data_i;
    logic [wbuf_pkg::WBUF_BE_WIDTH-1:0] write_be_i;
    logic send_valid_o;
    logic send_ready_i;
    logic [wbuf_pkg::WBUF_PA_WIDTH-1:0] send_addr_o;
    logic [wbuf_pkg::WBUF_DIR_PTR_WIDTH-1:0] send_id_o;
    logic [wbuf_pkg::WBUF_LINE_WIDTH-1:0] send_data_o;
    logic [wbuf_pkg::WBUF_LINE_BE_WIDTH-1:0] send_be_o;
    logic ack_i;
    logic [wbuf_pkg::WBUF_DIR_PTR_WIDTH-1:0] ack_id_i;
    logic empty_o;
    logic full_o;

    // Writes of the next line, then the expected sends in order
    logic [wbuf_pkg::WBUF_PA_WIDTH-1:0] pend_addr_q[$];
    logic [wbuf_pkg::WBUF_WORD_WIDTH-1:0] pend_data_q[$];
    logic [wbuf_pkg::WBUF_BE_WIDTH-1:0] pend_be_q[$];
    logic [wbuf_pkg::WBUF_PA_WIDTH-1:0] exp_addr_q[$];
    logic [wbuf_pkg::WBUF_LINE_WIDTH-1:0] exp_line_q[$];
    logic [wbuf_pkg::WBUF_LINE_BE_WIDTH-1:0] exp_be_q[$];
    logic [wbuf_pkg::WBUF_DIR_PTR_WIDTH-1:0] ack_id_q[$];
    int ack_due_q[$];
    int cycle_cnt = 0;
    int acks_done = 0;
    logic bp_en = 1'b0;
    logic [31:0] rnd_state = 32'he0d1;
    logic [31:0] bp_state = 32'he0d1;

    wbuf_top UUT (
        .clk_i                        (clk_i),
        .rst_ni                       (rst_ni),
        .cfg_threshold_i              (cfg_threshold_i),
        .cfg_reset_timecnt_on_write_i (cfg_reset_timecnt_on_write_i),
        .cfg_sequential_waw_i         (cfg_sequential_waw_i),
        .close_all_i                  (close_all_i),
        .write_i                      (write_i),
        .write_ready_o                (write_ready_o),
        .write_addr_i                 (write_addr_i),
        .write_data_i                 (write_data_i),
        .write_be_i                   (write_be_i),
        .send_valid_o                 (send_valid_o),
        .send_ready_i                 (send_ready_i),
        .send_addr_o                  (send_addr_o),
        .send_id_o                    (send_id_o),
        .send_data_o                  (send_data_o),
        .send_be_o                    (send_be_o),
        .ack_i                        (ack_i),
        .ack_id_i                     (ack_id_i),
        .empty_o                      (empty_o),
        .full_o                       (full_o)
    );

    always #20 clk_i = ~clk_i;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Later bytes win, enables accumulate, unwritten bytes stay zero
    function automatic logic [wbuf_pkg::WBUF_LINE_BE_WIDTH+wbuf_pkg::WBUF_LINE_WIDTH-1:0]
            wbuf_merge_line(input logic [wbuf_pkg::WBUF_PA_WIDTH-1:0] addrs[$],
                            input logic [wbuf_pkg::WBUF_WORD_WIDTH-1:0] words[$],
                            input logic [wbuf_pkg::WBUF_BE_WIDTH-1:0] bes[$]);
        logic [wbuf_pkg::WBUF_LINE_WIDTH-1:0] line;
        logic [wbuf_pkg::WBUF_LINE_BE_WIDTH-1:0] line_be;
        int lane;
        line = '0;
        line_be = '0;
        foreach (addrs[k]) begin
            for (int b = 0; b < wbuf_pkg::WBUF_BE_WIDTH; b++) begin
                lane = int'(addrs[k][wbuf_pkg::WBUF_OFFSET_WIDTH-1:wbuf_pkg::WBUF_WORD_OFFSET])
                       * wbuf_pkg::WBUF_BE_WIDTH + b;
                if (bes[k][b]) begin
                    line[lane*8 +: 8] = words[k][b*8 +: 8];
                    line_be[lane] = 1'b1;
                end
            end
        end
        return {line_be, line};
    endfunction

    // True while a line with this slot id still awaits its ack
    function automatic bit id_in_flight(input logic [wbuf_pkg::WBUF_DIR_PTR_WIDTH-1:0] id);
        bit found;
        found = 1'b0;
        foreach (ack_id_q[k]) begin
            if (ack_id_q[k] == id) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    task automatic abort_run();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR t=%0t %s expected %b actual %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_addr(input string name, input logic [wbuf_pkg::WBUF_PA_WIDTH-1:0] exp,
                              input logic [wbuf_pkg::WBUF_PA_WIDTH-1:0] act);
        if (act !== exp) begin
            $display("ERR t=%0t %s expected %h actual %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_line(input logic [wbuf_pkg::WBUF_LINE_WIDTH-1:0] exp_data, act_data,
                              input logic [wbuf_pkg::WBUF_LINE_BE_WIDTH-1:0] exp_be, act_be);
        if (act_data !== exp_data) begin
            $display("ERR t=%0t send_data_o expected %h actual %h", $time, exp_data, act_data);
            abort_run();
        end else if (act_be !== exp_be) begin
            $display("ERR t=%0t send_be_o expected %h actual %h", $time, exp_be, act_be);
            abort_run();
        end
    endtask

    task automatic add_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] be);
        pend_addr_q.push_back(addr);
        pend_data_q.push_back(data);
        pend_be_q.push_back(be);
    endtask

    task automatic expect_pending();
        logic [wbuf_pkg::WBUF_LINE_BE_WIDTH+wbuf_pkg::WBUF_LINE_WIDTH-1:0] merged;
        merged = wbuf_merge_line(pend_addr_q, pend_data_q, pend_be_q);
        exp_addr_q.push_back({pend_addr_q[0][wbuf_pkg::WBUF_PA_WIDTH-1:wbuf_pkg::WBUF_OFFSET_WIDTH],
                              {wbuf_pkg::WBUF_OFFSET_WIDTH{1'b0}}});
        exp_line_q.push_back(merged[wbuf_pkg::WBUF_LINE_WIDTH-1:0]);
        exp_be_q.push_back(merged[wbuf_pkg::WBUF_LINE_BE_WIDTH+wbuf_pkg::WBUF_LINE_WIDTH-1:
                                  wbuf_pkg::WBUF_LINE_WIDTH]);
    endtask

    // Called 2 ns after an edge, returns 2 ns after the accepting edge
    task automatic drive_write(input logic [31:0] addr, input logic [31:0] data,
                               input logic [3:0] be, output int stalls);
        logic accepted;
        stalls = 0;
        accepted = 1'b0;
        write_i = 1'b1;
        write_addr_i = addr;
        write_data_i = data;
        write_be_i = be;
        while (!accepted) begin
            @(negedge clk_i);
            accepted = write_ready_o;
            if (!accepted) begin
                stalls++;
            end
            @(posedge clk_i);
            #2;
        end
        write_i = 1'b0;
    endtask

    task automatic send_pending();
        int stalls;
        foreach (pend_addr_q[k]) begin
            drive_write(pend_addr_q[k], pend_data_q[k], pend_be_q[k], stalls);
        end
        pend_addr_q.delete();
        pend_data_q.delete();
        pend_be_q.delete();
    endtask

    task automatic wait_sent();
        do begin
            @(posedge clk_i);
            #2;
        end while (exp_addr_q.size() != 0);
    endtask

    task automatic wait_idle();
        do begin
            @(posedge clk_i);
            #2;
        end while (exp_addr_q.size() != 0 || ack_id_q.size() != 0);
        // Last ack frees its slot at the next edge
        @(posedge clk_i);
        @(negedge clk_i);
        check_flag("empty_o", 1'b1, empty_o);
        @(posedge clk_i);
        #2;
    endtask

    // About 1000 cycles of tests, mostly the random phase
    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= 4000) begin
            $display("Timeout after %0d cycles without finishing the tests", cycle_cnt);
            abort_run();
        end
    end

    // Handshake completes at the next rising edge
    always @(negedge clk_i) begin
        if (rst_ni && send_valid_o && send_ready_i) begin
            if (exp_addr_q.size() == 0) begin
                $display("Unexpected send of line %h at %0t", send_addr_o, $time);
                abort_run();
            end else if (id_in_flight(send_id_o)) begin
                $display("Slot id %0d sent while a line with that id still awaits its ack",
                         send_id_o);
                abort_run();
            end else begin
                check_addr("send_addr_o", exp_addr_q.pop_front(), send_addr_o);
                check_line(exp_line_q.pop_front(), send_data_o, exp_be_q.pop_front(), send_be_o);
                ack_id_q.push_back(send_id_o);
                ack_due_q.push_back(cycle_cnt + 3);
            end
        end
    end

    initial begin : ack_responder
        forever begin
            @(posedge clk_i);
            #2;
            ack_i = 1'b0;
            if (ack_id_q.size() != 0 && cycle_cnt >= ack_due_q[0]) begin
                ack_i = 1'b1;
                ack_id_i = ack_id_q.pop_front();
                void'(ack_due_q.pop_front());
                acks_done++;
            end
        end
    end

    initial begin : backpressure
        forever begin
            @(posedge clk_i);
            #2;
            if (bp_en) begin
                bp_state = lcg_next(bp_state);
                send_ready_i = bp_state[16];
            end
        end
    end

    initial begin : stimulus
        logic [1:0] line_sel;
        int stalls;
        int acks_before;
        rst_ni = 1'b0;
        cfg_threshold_i = '0;
        cfg_reset_timecnt_on_write_i = 1'b0;
        cfg_sequential_waw_i = 1'b0;
        close_all_i = 1'b0;
        write_i = 1'b0;
        write_addr_i = '0;
        write_data_i = '0;
        write_be_i = '0;
        send_ready_i = 1'b1;
        ack_i = 1'b0;
        ack_id_i = '0;
        repeat (10) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;

        @(negedge clk_i);
        check_flag("empty_o", 1'b1, empty_o);
        check_flag("full_o", 1'b0, full_o);
        check_flag("send_valid_o", 1'b0, send_valid_o);
        check_flag("write_ready_o", 1'b1, write_ready_o);
        @(posedge clk_i);
        #2;

        // Four words merge into one line
        cfg_threshold_i = 3'd7;
        add_write(32'h0000_1040, 32'hA1A2_A3A4, 4'hF);
        add_write(32'h0000_1044, 32'hB1B2_B3B4, 4'h3);
        add_write(32'h0000_1048, 32'hC1C2_C3C4, 4'hC);
        add_write(32'h0000_104C, 32'hD1D2_D3D4, 4'h9);
        expect_pending();
        send_pending();
        close_all_i = 1'b1;
        wait_idle();
        close_all_i = 1'b0;

        // Fill every slot while the send side is blocked
        cfg_threshold_i = '0;
        send_ready_i = 1'b0;
        for (int i = 0; i < wbuf_pkg::WBUF_DIR_ENTRIES; i++) begin
            add_write(32'h0000_2000 + 32'(i * 16), 32'h5500_0000 + 32'(i), 4'hF);
            expect_pending();
            send_pending();
        end
        write_addr_i = 32'h0000_2F00;
        repeat (6) @(posedge clk_i);
        @(negedge clk_i);
        check_flag("full_o", 1'b1, full_o);
        check_flag("write_ready_o", 1'b0, write_ready_o);
        check_flag("send_valid_o", 1'b1, send_valid_o);
        @(posedge clk_i);
        #2;
        send_ready_i = 1'b1;
        wait_idle();

        // Write to a sent line waits for its ack
        cfg_sequential_waw_i = 1'b1;
        add_write(32'h0000_1200, 32'h1111_2222, 4'hF);
        expect_pending();
        send_pending();
        wait_sent();
        add_write(32'h0000_1204, 32'h3333_4444, 4'h6);
        expect_pending();
        acks_before = acks_done;
        drive_write(32'h0000_1204, 32'h3333_4444, 4'h6, stalls);
        if (stalls == 0 || acks_done == acks_before) begin
            $display("Write to a sent line was accepted before its acknowledge");
            abort_run();
        end
        pend_addr_q.delete();
        pend_data_q.delete();
        pend_be_q.delete();
        wait_idle();
        cfg_sequential_waw_i = 1'b0;

        // Overlapping bytes, then closed by timeout alone
        cfg_threshold_i = 3'd3;
        cfg_reset_timecnt_on_write_i = 1'b1;
        add_write(32'h0000_1304, 32'h0102_0304, 4'h3);
        add_write(32'h0000_1304, 32'hF0E0_D0C0, 4'h6);
        expect_pending();
        send_pending();
        wait_idle();
        cfg_reset_timecnt_on_write_i = 1'b0;

        // Random single writes over three lines with back-pressure
        cfg_threshold_i = '0;
        bp_en = 1'b1;
        for (int n = 0; n < 200; n++) begin
            rnd_state = lcg_next(rnd_state);
            line_sel = 2'(rnd_state[23:16] % 8'd3);
            add_write({20'h00003, 6'd0, line_sel, rnd_state[5:4], 2'b00},
                      lcg_next(rnd_state), rnd_state[11:8]);
            expect_pending();
            send_pending();
            // Idle gap lets the closed slot reach the send queue
            repeat (2) begin
                @(posedge clk_i);
                #2;
            end
        end
        wait_idle();

        $display("All tests passed!");
        $finish;
    end

endmodule

/* hdl/wbuf_top.sv */
// ack_id_i must name a slot in the SENT state; acks are expected in send order
`timescale 1ns/100ps
module wbuf_top (
    input  logic                                      clk_i,
    input  logic                                      rst_ni,
    input  logic [wbuf_pkg::WBUF_TIMECNT_WIDTH-1:0]   cfg_threshold_i,
    input  logic                                      cfg_reset_timecnt_on_write_i,
    input  logic                                      cfg_sequential_waw_i,
    input  logic                                      close_all_i,
    input  logic                                      write_i,
    output logic                                      write_ready_o,
    input  logic [wbuf_pkg::WBUF_PA_WIDTH-1:0]        write_addr_i,
    input  logic [wbuf_pkg::WBUF_WORD_WIDTH-1:0]      write_data_i,
    input  logic [wbuf_pkg::WBUF_BE_WIDTH-1:0]        write_be_i,
    output logic                                      send_valid_o,
    input  logic                                      send_ready_i,
    output logic [wbuf_pkg::WBUF_PA_WIDTH-1:0]        send_addr_o,
    output logic [wbuf_pkg::WBUF_DIR_PTR_WIDTH-1:0]   send_id_o,
    output logic [wbuf_pkg::WBUF_LINE_WIDTH-1:0]      send_data_o,
    output logic [wbuf_pkg::WBUF_LINE_BE_WIDTH-1:0]   send_be_o,
    input  logic                                      ack_i,
    input  logic [wbuf_pkg::WBUF_DIR_PTR_WIDTH-1:0]   ack_id_i,
    output logic                                      empty_o,
    output logic                                      full_o
);

    logic data_alloc;
    logic data_merge;
    logic data_free;
    logic [wbuf_pkg::WBUF_DATA_PTR_WIDTH-1:0] merge_ptr;
    logic [wbuf_pkg::WBUF_DATA_PTR_WIDTH-1:0] data_free_ptr;
    logic enq;
    logic enq_ok;
    logic [wbuf_pkg::WBUF_DIR_PTR_WIDTH-1:0] enq_id;
    logic [wbuf_pkg::WBUF_TAG_WIDTH-1:0] enq_tag;
    logic [wbuf_pkg::WBUF_DATA_PTR_WIDTH-1:0] enq_ptr;
    logic [wbuf_pkg::WBUF_DATA_PTR_WIDTH-1:0] rd_ptr;
    logic rd_release;
    logic [wbuf_pkg::WBUF_LINE_WIDTH-1:0] rd_data;
    logic [wbuf_pkg::WBUF_LINE_BE_WIDTH-1:0] rd_be;

    // Lookup, allocation and slot life cycle
    wbuf_dir u_dir (
        .clk_i                        (clk_i),
        .rst_ni                       (rst_ni),
        .write_i                      (write_i),
        .write_addr_i                 (write_addr_i),
        .cfg_threshold_i              (cfg_threshold_i),
        .cfg_reset_timecnt_on_write_i (cfg_reset_timecnt_on_write_i),
        .cfg_sequential_waw_i         (cfg_sequential_waw_i),
        .close_all_i                  (close_all_i),
        .ack_i                        (ack_i),
        .ack_id_i                     (ack_id_i),
        .data_free                    (data_free),
        .data_free_ptr                (data_free_ptr),
        .enq_ok                       (enq_ok),
        .write_ready_o                (write_ready_o),
        .empty_o                      (empty_o),
        .full_o                       (full_o),
        .data_alloc                   (data_alloc),
        .data_merge                   (data_merge),
        .merge_ptr                    (merge_ptr),
        .enq                          (enq),
        .enq_id                       (enq_id),
        .enq_tag                      (enq_tag),
        .enq_ptr                      (enq_ptr)
    );

    wbuf_data_store u_data_store (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .write_addr_i  (write_addr_i),
        .write_data_i  (write_data_i),
        .write_be_i    (write_be_i),
        .data_alloc    (data_alloc),
        .data_merge    (data_merge),
        .merge_ptr     (merge_ptr),
        .rd_ptr        (rd_ptr),
        .rd_release    (rd_release),
        .data_free     (data_free),
        .data_free_ptr (data_free_ptr),
        .rd_data       (rd_data),
        .rd_be         (rd_be)
    );

    wbuf_send_queue u_send_queue (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .enq          (enq),
        .enq_id       (enq_id),
        .enq_tag      (enq_tag),
        .enq_ptr      (enq_ptr),
        .rd_data      (rd_data),
        .rd_be        (rd_be),
        .send_ready_i (send_ready_i),
        .enq_ok       (enq_ok),
        .rd_ptr       (rd_ptr),
        .rd_release   (rd_release),
        .send_valid_o (send_valid_o),
        .send_addr_o  (send_addr_o),
        .send_id_o    (send_id_o),
        .send_data_o  (send_data_o),
        .send_be_o    (send_be_o)
    );

endmodule

/* hdl/wbuf_send_queue.sv */
// Enqueue is only legal while enq_ok is high; the line is read from the store at the head
`timescale 1ns/100ps
module wbuf_send_queue (
    input  logic                                      clk_i,
    input  logic                                      rst_ni,
    input  logic                                      enq,
    input  logic [wbuf_pkg::WBUF_DIR_PTR_WIDTH-1:0]   enq_id,
    input  logic [wbuf_pkg::WBUF_TAG_WIDTH-1:0]       enq_tag,
    input  logic [wbuf_pkg::WBUF_DATA_PTR_WIDTH-1:0]  enq_ptr,
    input  logic [wbuf_pkg::WBUF_LINE_WIDTH-1:0]      rd_data,
    input  logic [wbuf_pkg::WBUF_LINE_BE_WIDTH-1:0]   rd_be,
    input  logic                                      send_ready_i,
    output logic                                      enq_ok,
    output logic [wbuf_pkg::WBUF_DATA_PTR_WIDTH-1:0]  rd_ptr,
    output logic                                      rd_release,
    output logic                                      send_valid_o,
    output logic [wbuf_pkg::WBUF_PA_WIDTH-1:0]        send_addr_o,
    output logic [wbuf_pkg::WBUF_DIR_PTR_WIDTH-1:0]   send_id_o,
    output logic [wbuf_pkg::WBUF_LINE_WIDTH-1:0]      send_data_o,
    output logic [wbuf_pkg::WBUF_LINE_BE_WIDTH-1:0]   send_be_o
);

    logic [wbuf_pkg::WBUF_DIR_PTR_WIDTH-1:0] id_q [wbuf_pkg::WBUF_SEND_DEPTH];
    logic [wbuf_pkg::WBUF_TAG_WIDTH-1:0] tag_q [wbuf_pkg::WBUF_SEND_DEPTH];
    logic [wbuf_pkg::WBUF_DATA_PTR_WIDTH-1:0] ptr_q [wbuf_pkg::WBUF_SEND_DEPTH];
    // Depth equals the buffer count, so buffer-pointer width indexes the FIFO
    logic [wbuf_pkg::WBUF_DATA_PTR_WIDTH-1:0] head_q, tail_q;
    logic [wbuf_pkg::WBUF_DATA_PTR_WIDTH:0] count_q;

    assign enq_ok = (count_q != wbuf_pkg::WBUF_SEND_DEPTH);
    assign send_valid_o = (count_q != '0);
    assign rd_release = send_valid_o & send_ready_i;

    always_ff @(posedge clk_i) begin
        if (enq) begin
            id_q[tail_q] <= enq_id;
            tag_q[tail_q] <= enq_tag;
            ptr_q[tail_q] <= enq_ptr;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            head_q <= '0;
            tail_q <= '0;
            count_q <= '0;
        end else begin
            if (enq) begin
                tail_q <= tail_q + 1'b1;
            end
            if (rd_release) begin
                head_q <= head_q + 1'b1;
            end
            case ({enq, rd_release})
                2'b10: count_q <= count_q + 1'b1;
                2'b01: count_q <= count_q - 1'b1;
                default: ;
            endcase
        end
    end

    // Payload from the head entry and its line in the store
    assign rd_ptr = ptr_q[head_q];
    assign send_addr_o = {tag_q[head_q], {wbuf_pkg::WBUF_OFFSET_WIDTH{1'b0}}};
    assign send_id_o = id_q[head_q];
    assign send_data_o = rd_data;
    assign send_be_o = rd_be;

endmodule

/* hdl/wbuf_data_store.sv */
// Buffers are handed out round robin and must be released in the same order
`timescale 1ns/100ps
module wbuf_data_store (
    input  logic                                      clk_i,
    input  logic                                      rst_ni,
    input  logic [wbuf_pkg::WBUF_PA_WIDTH-1:0]        write_addr_i,
    input  logic [wbuf_pkg::WBUF_WORD_WIDTH-1:0]      write_data_i,
    input  logic [wbuf_pkg::WBUF_BE_WIDTH-1:0]        write_be_i,
    input  logic                                      data_alloc,
    input  logic                                      data_merge,
    input  logic [wbuf_pkg::WBUF_DATA_PTR_WIDTH-1:0]  merge_ptr,
    input  logic [wbuf_pkg::WBUF_DATA_PTR_WIDTH-1:0]  rd_ptr,
    input  logic                                      rd_release,
    output logic                                      data_free,
    output logic [wbuf_pkg::WBUF_DATA_PTR_WIDTH-1:0]  data_free_ptr,
    output logic [wbuf_pkg::WBUF_LINE_WIDTH-1:0]      rd_data,
    output logic [wbuf_pkg::WBUF_LINE_BE_WIDTH-1:0]   rd_be
);

    logic [wbuf_pkg::WBUF_LINE_WIDTH-1:0] data_q [wbuf_pkg::WBUF_DATA_ENTRIES];
    logic [wbuf_pkg::WBUF_LINE_BE_WIDTH-1:0] be_q [wbuf_pkg::WBUF_DATA_ENTRIES];
    logic [wbuf_pkg::WBUF_DATA_ENTRIES-1:0] valid_q;
    logic [wbuf_pkg::WBUF_DATA_PTR_WIDTH-1:0] free_ptr_q;
    logic [wbuf_pkg::WBUF_DATA_PTR_WIDTH-1:0] wr_ptr;
    logic [wbuf_pkg::WBUF_OFFSET_WIDTH-wbuf_pkg::WBUF_WORD_OFFSET-1:0] word_idx;
    logic [wbuf_pkg::WBUF_LINE_WIDTH-1:0] new_data, old_data, merged_data;
    logic [wbuf_pkg::WBUF_LINE_BE_WIDTH-1:0] new_be, old_be;

    assign word_idx = write_addr_i[wbuf_pkg::WBUF_OFFSET_WIDTH-1:wbuf_pkg::WBUF_WORD_OFFSET];
    assign wr_ptr = data_alloc ? free_ptr_q : merge_ptr;
    assign new_data = {wbuf_pkg::WBUF_WORDS{write_data_i}};

    // Word lands in every lane, enables pick the addressed one
    always_comb begin
        for (int w = 0; w < wbuf_pkg::WBUF_WORDS; w++) begin
            new_be[w*wbuf_pkg::WBUF_BE_WIDTH +: wbuf_pkg::WBUF_BE_WIDTH] =
                (int'(word_idx) == w) ? write_be_i : '0;
        end
    end

    // A fresh buffer starts from zero, a merge starts from what is stored
    always_comb begin
        old_data = data_alloc ? '0 : data_q[wr_ptr];
        old_be = data_alloc ? '0 : be_q[wr_ptr];
        for (int b = 0; b < wbuf_pkg::WBUF_LINE_BE_WIDTH; b++) begin
            merged_data[b*8 +: 8] = new_be[b] ? new_data[b*8 +: 8] : old_data[b*8 +: 8];
        end
    end

    always_ff @(posedge clk_i) begin
        if (data_alloc || data_merge) begin
            data_q[wr_ptr] <= merged_data;
            be_q[wr_ptr] <= old_be | new_be;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
            free_ptr_q <= '0;
        end else begin
            if (data_alloc) begin
                valid_q[free_ptr_q] <= 1'b1;
                free_ptr_q <= free_ptr_q + 1'b1;
            end
            if (rd_release) begin
                valid_q[rd_ptr] <= 1'b0;
            end
        end
    end

    assign data_free = ~valid_q[free_ptr_q];
    assign data_free_ptr = free_ptr_q;
    assign rd_data = data_q[rd_ptr];
    assign rd_be = be_q[rd_ptr];

endmodule

/* hdl/wbuf_dir.sv */
// Slots are allocated strictly round robin, so acks are expected to return in send order
`timescale 1ns/100ps
module wbuf_dir (
    input  logic                                      clk_i,
    input  logic                                      rst_ni,
    input  logic                                      write_i,
    input  logic [wbuf_pkg::WBUF_PA_WIDTH-1:0]        write_addr_i,
    input  logic [wbuf_pkg::WBUF_TIMECNT_WIDTH-1:0]   cfg_threshold_i,
    input  logic                                      cfg_reset_timecnt_on_write_i,
    input  logic                                      cfg_sequential_waw_i,
    input  logic                                      close_all_i,
    input  logic                                      ack_i,
    input  logic [wbuf_pkg::WBUF_DIR_PTR_WIDTH-1:0]   ack_id_i,
    input  logic                                      data_free,
    input  logic [wbuf_pkg::WBUF_DATA_PTR_WIDTH-1:0]  data_free_ptr,
    input  logic                                      enq_ok,
    output logic                                      write_ready_o,
    output logic                                      empty_o,
    output logic                                      full_o,
    output logic                                      data_alloc,
    output logic                                      data_merge,
    output logic [wbuf_pkg::WBUF_DATA_PTR_WIDTH-1:0]  merge_ptr,
    output logic                                      enq,
    output logic [wbuf_pkg::WBUF_DIR_PTR_WIDTH-1:0]   enq_id,
    output logic [wbuf_pkg::WBUF_TAG_WIDTH-1:0]       enq_tag,
    output logic [wbuf_pkg::WBUF_DATA_PTR_WIDTH-1:0]  enq_ptr
);

    logic [wbuf_pkg::WBUF_DIR_ENTRIES-1:0][1:0] state_q, state_d;
    logic [wbuf_pkg::WBUF_DIR_ENTRIES-1:0][wbuf_pkg::WBUF_TAG_WIDTH-1:0] tag_q, tag_d;
    logic [wbuf_pkg::WBUF_DIR_ENTRIES-1:0][wbuf_pkg::WBUF_TIMECNT_WIDTH-1:0] cnt_q, cnt_d;
    logic [wbuf_pkg::WBUF_DIR_ENTRIES-1:0][wbuf_pkg::WBUF_DATA_PTR_WIDTH-1:0] ptr_q, ptr_d;
    logic [wbuf_pkg::WBUF_DIR_ENTRIES-1:0] closed_vec;
    logic [wbuf_pkg::WBUF_DIR_PTR_WIDTH-1:0] alloc_ptr_q;
    logic [wbuf_pkg::WBUF_DIR_PTR_WIDTH-1:0] send_ptr_q, send_ptr_d;
    logic [wbuf_pkg::WBUF_DIR_PTR_WIDTH-1:0] hit_slot;
    logic [wbuf_pkg::WBUF_TAG_WIDTH-1:0] write_tag;
    logic hit_open;
    logic hit_closed;
    logic hit_sent;
    logic write_free;

    // Nearest closed slot after cur, or cur itself when there is none
    function automatic logic [wbuf_pkg::WBUF_DIR_PTR_WIDTH-1:0] find_next_closed(
            input logic [wbuf_pkg::WBUF_DIR_PTR_WIDTH-1:0] cur,
            input logic [wbuf_pkg::WBUF_DIR_ENTRIES-1:0] closed);
        logic [wbuf_pkg::WBUF_DIR_PTR_WIDTH-1:0] nxt;
        logic [wbuf_pkg::WBUF_DIR_PTR_WIDTH-1:0] res;
        res = cur;
        for (int i = wbuf_pkg::WBUF_DIR_ENTRIES - 1; i >= 1; i--) begin
            nxt = cur + i[wbuf_pkg::WBUF_DIR_PTR_WIDTH-1:0];
            if (closed[nxt]) begin
                res = nxt;
            end
        end
        return res;
    endfunction

    assign write_tag = write_addr_i[wbuf_pkg::WBUF_PA_WIDTH-1:wbuf_pkg::WBUF_OFFSET_WIDTH];

    // Tag lookup across all slots, plus the global flags
    always_comb begin
        hit_open = 1'b0;
        hit_closed = 1'b0;
        hit_sent = 1'b0;
        hit_slot = '0;
        empty_o = 1'b1;
        full_o = 1'b1;
        for (int i = 0; i < wbuf_pkg::WBUF_DIR_ENTRIES; i++) begin
            closed_vec[i] = (state_q[i] == wbuf_pkg::WBUF_CLOSED);
            empty_o &= (state_q[i] == wbuf_pkg::WBUF_FREE);
            full_o &= (state_q[i] != wbuf_pkg::WBUF_FREE);
            if (tag_q[i] == write_tag) begin
                case (state_q[i])
                    wbuf_pkg::WBUF_OPEN: begin
                        hit_open = 1'b1;
                        hit_slot = i[wbuf_pkg::WBUF_DIR_PTR_WIDTH-1:0];
                    end
                    wbuf_pkg::WBUF_CLOSED: begin
                        hit_closed = 1'b1;
                        hit_slot = i[wbuf_pkg::WBUF_DIR_PTR_WIDTH-1:0];
                    end
                    wbuf_pkg::WBUF_SENT: hit_sent = 1'b1;
                    default: ;
                endcase
            end
        end
    end

    // A sent hit may take a new slot unless WAW is sequenced
    assign write_free = (state_q[alloc_ptr_q] == wbuf_pkg::WBUF_FREE) & data_free
                      & ~hit_open & ~hit_closed & ~(hit_sent & cfg_sequential_waw_i);
    assign write_ready_o = write_free | hit_open | hit_closed;
    assign data_alloc = write_i & write_free;
    assign data_merge = write_i & (hit_open | hit_closed);
    assign merge_ptr = ptr_q[hit_slot];

    // Head of the send order goes to the queue when there is room
    assign enq = closed_vec[send_ptr_q] & enq_ok;
    assign enq_id = send_ptr_q;
    assign enq_tag = tag_q[send_ptr_q];
    assign enq_ptr = ptr_q[send_ptr_q];

    always_comb begin
        send_ptr_d = send_ptr_q;
        if (!closed_vec[send_ptr_q] || enq) begin
            send_ptr_d = find_next_closed(send_ptr_q, closed_vec);
        end
    end

    // Per-slot state, time counter and close
    always_comb begin
        logic timeout;
        logic hit_here;
        state_d = state_q;
        tag_d = tag_q;
        cnt_d = cnt_q;
        ptr_d = ptr_q;
        for (int i = 0; i < wbuf_pkg::WBUF_DIR_ENTRIES; i++) begin
            case (state_q[i])
                wbuf_pkg::WBUF_FREE: begin
                    if (data_alloc && (int'(alloc_ptr_q) == i)) begin
                        state_d[i] = ((cfg_threshold_i == '0) || close_all_i) ?
                                     wbuf_pkg::WBUF_CLOSED : wbuf_pkg::WBUF_OPEN;
                        tag_d[i] = write_tag;
                        cnt_d[i] = '0;
                        ptr_d[i] = data_free_ptr;
                    end
                end
                wbuf_pkg::WBUF_OPEN: begin
                    hit_here = data_merge && (int'(hit_slot) == i);
                    timeout = (cnt_q[i] == cfg_threshold_i - 1'b1);
                    if (hit_here && cfg_reset_timecnt_on_write_i) begin
                        timeout = 1'b0;
                        cnt_d[i] = '0;
                    end else if (!timeout) begin
                        cnt_d[i] = cnt_q[i] + 1'b1;
                    end
                    if (timeout || close_all_i) begin
                        state_d[i] = wbuf_pkg::WBUF_CLOSED;
                    end
                end
                wbuf_pkg::WBUF_CLOSED: begin
                    if (enq && (int'(send_ptr_q) == i)) begin
                        state_d[i] = wbuf_pkg::WBUF_SENT;
                    end
                end
                default: begin
                    if (ack_i && (int'(ack_id_i) == i)) begin
                        state_d[i] = wbuf_pkg::WBUF_FREE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= {wbuf_pkg::WBUF_DIR_ENTRIES{wbuf_pkg::WBUF_FREE}};
            alloc_ptr_q <= '0;
            send_ptr_q <= '0;
        end else begin
            state_q <= state_d;
            send_ptr_q <= send_ptr_d;
            if (data_alloc) begin
                alloc_ptr_q <= alloc_ptr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        tag_q <= tag_d;
        cnt_q <= cnt_d;
        ptr_q <= ptr_d;
    end

endmodule

/* hdl/wbuf_pkg.sv */
// Geometry is fixed here; widths below must stay consistent with the entry counts by hand
package wbuf_pkg;

    // Slot and buffer counts
    localparam int WBUF_DIR_ENTRIES = 4;
    localparam int WBUF_DATA_ENTRIES = 4;

    // Address and word geometry
    localparam int WBUF_PA_WIDTH = 32;
    localparam int WBUF_WORD_WIDTH = 32;
    localparam int WBUF_WORDS = 4;
    localparam int WBUF_BE_WIDTH = WBUF_WORD_WIDTH / 8;
    localparam int WBUF_OFFSET_WIDTH = 4;
    localparam int WBUF_WORD_OFFSET = 2;
    localparam int WBUF_TAG_WIDTH = WBUF_PA_WIDTH - WBUF_OFFSET_WIDTH;

    // One line of data and its byte enables
    localparam int WBUF_LINE_WIDTH = WBUF_WORD_WIDTH * WBUF_WORDS;
    localparam int WBUF_LINE_BE_WIDTH = WBUF_BE_WIDTH * WBUF_WORDS;

    // Pointer widths
    localparam int WBUF_DIR_PTR_WIDTH = 2;
    localparam int WBUF_DATA_PTR_WIDTH = 2;

    // Time counter and threshold
    localparam int WBUF_TIMECNT_WIDTH = 3;

    // Send queue holds at most one entry per data buffer
    localparam int WBUF_SEND_DEPTH = WBUF_DATA_ENTRIES;

    // Slot states
    localparam logic [1:0] WBUF_FREE = 2'b00;
    localparam logic [1:0] WBUF_OPEN = 2'b01;
    localparam logic [1:0] WBUF_CLOSED = 2'b10;
    localparam logic [1:0] WBUF_SENT = 2'b11;

endpackage
